//--- verilog/chip8_macros.svh
`ifndef CHIP8_MACROS_SVH
`define CHIP8_MACROS_SVH

// program address space
`define CHIP8_ADDR_W       12
`define CHIP8_MEM_DEPTH    4096
`define CHIP8_PC_RESET     12'h200

// call stack
`define CHIP8_STACK_DEPTH  16

// bit 12 of paddr selects program memory
`define CHIP8_PADDR_W      13

// register offsets, paddr[11:0] with bit 12 clear
`define CHIP8_REG_CTRL     12'h000
`define CHIP8_REG_STATUS   12'h004
`define CHIP8_REG_I        12'h008
`define CHIP8_REG_V_BASE   12'h040

`endif

//--- verilog/chip8_isa_pkg.sv
`include "chip8_macros.svh"

package chip8_isa_pkg;

   typedef logic [7:0]               byte_t;
   typedef logic [`CHIP8_ADDR_W-1:0] addr_t;
   typedef logic [3:0]               vidx_t;

   // major opcode, top nibble of the high byte
   typedef enum logic [3:0] {
      OP_SYS      = 4'h0,
      OP_JP       = 4'h1,
      OP_CALL     = 4'h2,
      OP_SE_BYTE  = 4'h3,
      OP_SNE_BYTE = 4'h4,
      OP_SE_REG   = 4'h5,
      OP_LD_BYTE  = 4'h6,
      OP_ADD_BYTE = 4'h7,
      OP_ALU      = 4'h8,
      OP_SNE_REG  = 4'h9,
      OP_LD_I     = 4'hA,
      OP_JP_V0    = 4'hB,
      OP_RND      = 4'hC,
      OP_DRW      = 4'hD,
      OP_SKP      = 4'hE,
      OP_MISC     = 4'hF
   } op_e;

   // 8xyN sub-operations
   typedef enum logic [3:0] {
      ALU_LD   = 4'h0,
      ALU_OR   = 4'h1,
      ALU_AND  = 4'h2,
      ALU_XOR  = 4'h3,
      ALU_ADD  = 4'h4,
      ALU_SUB  = 4'h5,
      ALU_SHR  = 4'h6,
      ALU_SUBN = 4'h7,
      ALU_SHL  = 4'hE
   } alu_e;

   typedef struct packed {
      op_e   op;
      vidx_t x;
      vidx_t y;
      logic [3:0] n;
      byte_t kk;
      addr_t nnn;
   } instr_t;

endpackage

//--- verilog/chip8_apb_pkg.sv
`include "chip8_macros.svh"

package chip8_apb_pkg;
   import chip8_isa_pkg::*;

   typedef struct packed {
      logic                      psel;
      logic                      penable;
      logic                      pwrite;
      logic [`CHIP8_PADDR_W-1:0] paddr;
      logic [31:0]               pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic  we;
      addr_t addr;
      byte_t data;
   } mem_wr_t;

   typedef struct packed {
      logic        running;
      addr_t       pc;
      logic [15:0] i_reg;
   } core_status_t;

endpackage

//--- verilog/chip8_ram.sv
module chip8_ram
   import chip8_isa_pkg::*;
#(
   parameter type payload_t = byte_t,
   parameter int  depth     = 16
)
(
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] waddr,
   input  payload_t                 d,
   input  logic [$clog2(depth)-1:0] raddr,
   output payload_t                 q
);

   payload_t mem [depth];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= d;
      end
      q <= mem[raddr]; // old data on same-address write
   end

endmodule

//--- verilog/chip8_apb_host.sv
`include "chip8_macros.svh"

module chip8_apb_host
   import chip8_isa_pkg::*;
   import chip8_apb_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  apb_req_t     req,
   input  core_status_t status,
   input  byte_t        dbg_vdata,
   output apb_rsp_t     rsp,
   output mem_wr_t      prog_wr,
   output logic         start,
   output vidx_t        dbg_vidx
);

   logic                     setup;
   logic                     access;
   logic                     is_mem;
   logic [`CHIP8_ADDR_W-1:0] offset;
   logic [`CHIP8_ADDR_W-1:0] v_off;
   logic                     hit_ctrl;
   logic                     hit_status;
   logic                     hit_i;
   logic                     hit_v;
   logic                     err;
   logic [31:0]              rdata;
   logic                     pready_q;
   logic                     pslverr_q;
   logic                     wr_pend_q;
   logic                     start_pend_q;
   logic [31:0]              prdata_q;
   addr_t                    wr_addr_q;
   byte_t                    wr_data_q;

   assign setup  = req.psel & ~req.penable;
   assign access = req.psel & req.penable;
   assign is_mem = req.paddr[`CHIP8_ADDR_W];
   assign offset = req.paddr[`CHIP8_ADDR_W-1:0];
   assign v_off  = offset - `CHIP8_REG_V_BASE;

   assign hit_ctrl   = ~is_mem & (offset == `CHIP8_REG_CTRL);
   assign hit_status = ~is_mem & (offset == `CHIP8_REG_STATUS);
   assign hit_i      = ~is_mem & (offset == `CHIP8_REG_I);
   assign hit_v      = ~is_mem & (v_off < 12'd64) & (v_off[1:0] == 2'b00);
   assign dbg_vidx   = v_off[5:2]; // word per V register

   always_comb
   begin
      if (is_mem)
         err = req.pwrite & status.running;
      else if (!(hit_ctrl | hit_status | hit_i | hit_v))
         err = 1'b1; // unmapped
      else
         err = req.pwrite & ~hit_ctrl; // only CTRL is writable
   end

   always_comb
   begin
      rdata = 32'h0;
      if (hit_status)
         rdata = {4'h0, status.pc, 15'h0, status.running};
      else if (hit_i)
         rdata = {16'h0, status.i_reg};
      else if (hit_v)
         rdata = {24'h0, dbg_vdata};
   end

   // decode in setup, answer in access
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pready_q     <= 1'b0;
         pslverr_q    <= 1'b0;
         wr_pend_q    <= 1'b0;
         start_pend_q <= 1'b0;
      end
      else
      begin
         pready_q     <= setup;
         pslverr_q    <= setup & err;
         wr_pend_q    <= setup & is_mem & req.pwrite & ~err;
         start_pend_q <= setup & hit_ctrl & req.pwrite & req.pwdata[0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (setup)
      begin
         prdata_q  <= req.pwrite ? 32'h0 : rdata;
         wr_addr_q <= offset;
         wr_data_q <= req.pwdata[7:0];
      end
   end

   assign rsp = '{prdata: prdata_q, pready: pready_q & access, pslverr: pslverr_q & access};
   assign prog_wr = '{we: wr_pend_q & access, addr: wr_addr_q, data: wr_data_q};
   assign start = start_pend_q & access;

endmodule

//--- verilog/chip8_exec.sv
`include "chip8_macros.svh"

module chip8_exec
   import chip8_isa_pkg::*;
   import chip8_apb_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     start,
   input  vidx_t                                    dbg_vidx,
   input  byte_t                                    mem_q,
   input  addr_t                                    stack_q,
   output core_status_t                             status,
   output byte_t                                    dbg_vdata,
   output addr_t                                    mem_raddr,
   output logic                                     stack_we,
   output logic [$clog2(`CHIP8_STACK_DEPTH)-1:0]    stack_waddr,
   output logic [$clog2(`CHIP8_STACK_DEPTH)-1:0]    stack_raddr,
   output addr_t                                    stack_d
);

   localparam int SP_W = $clog2(`CHIP8_STACK_DEPTH);

   typedef enum logic [1:0] {ST_FETCH, ST_HIGH, ST_LOW, ST_EXEC} state_e;

   state_e          state;
   logic            running;
   addr_t           pc;
   logic [15:0]     i_reg;
   byte_t           v [16];
   logic [SP_W-1:0] sp;
   byte_t           hi_q;
   byte_t           lo_q;
   instr_t          ins;
   byte_t           vx;
   byte_t           vy;
   byte_t           alu_res;
   logic            alu_flag;
   logic            alu_wr;
   logic            flag_we;
   addr_t           pc_next2;
   logic            exec_en;

   assign ins = '{op: op_e'(hi_q[7:4]), x: hi_q[3:0], y: lo_q[7:4], n: lo_q[3:0],
                  kk: lo_q, nnn: {hi_q[3:0], lo_q}};
   assign vx       = v[ins.x];
   assign vy       = v[ins.y];
   assign pc_next2 = pc + 12'd2;
   assign exec_en  = running & (state == ST_EXEC);

   assign mem_raddr   = (state == ST_HIGH) ? pc + 12'd1 : pc; // low byte at pc+1
   assign stack_we    = exec_en & (ins.op == OP_CALL);
   assign stack_waddr = sp;
   assign stack_raddr = sp - SP_W'(1); // top of stack for 00EE
   assign stack_d     = pc_next2;

   assign status    = '{running: running, pc: pc, i_reg: i_reg};
   assign dbg_vdata = v[dbg_vidx];

   always_comb
   begin
      alu_res  = vx;
      alu_flag = 1'b0;
      alu_wr   = 1'b1;
      flag_we  = 1'b0;
      case (alu_e'(ins.n))
         ALU_LD:  alu_res = vy;
         ALU_OR:  alu_res = vx | vy;
         ALU_AND: alu_res = vx & vy;
         ALU_XOR: alu_res = vx ^ vy;
         ALU_ADD:
         begin
            {alu_flag, alu_res} = {1'b0, vx} + {1'b0, vy};
            flag_we = 1'b1;
         end
         ALU_SUB:
         begin
            alu_res  = vx - vy;
            alu_flag = vx > vy; // strict, no flag on equal
            flag_we  = 1'b1;
         end
         ALU_SHR:
         begin
            alu_res  = vx >> 1;
            alu_flag = vx[0];
            flag_we  = 1'b1;
         end
         ALU_SUBN:
         begin
            alu_res  = vy - vx;
            alu_flag = vy > vx;
            flag_we  = 1'b1;
         end
         ALU_SHL:
         begin
            alu_res  = vx << 1;
            alu_flag = vx[7];
            flag_we  = 1'b1;
         end
         default: alu_wr = 1'b0; // undefined sub-op, no-op
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_HIGH)
         hi_q <= mem_q;
      if (state == ST_LOW)
         lo_q <= mem_q;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state   <= ST_FETCH;
         running <= 1'b0;
         pc      <= `CHIP8_PC_RESET;
         i_reg   <= 16'h0;
         sp      <= '0;
         for (int k = 0; k < 16; k++)
            v[k] <= 8'h0;
      end
      else if (!running)
      begin
         state <= ST_FETCH;
         if (start)
         begin
            running <= 1'b1;
            pc      <= `CHIP8_PC_RESET;
            sp      <= '0;
         end
      end
      else
      begin
         case (state)
            ST_FETCH: state <= ST_HIGH;
            ST_HIGH:  state <= ST_LOW;
            ST_LOW:   state <= ST_EXEC;
            ST_EXEC:
            begin
               state <= ST_FETCH;
               pc    <= pc_next2;
               case (ins.op)
                  OP_SYS:
                     if (ins.nnn == 12'h0EE)
                     begin
                        pc <= stack_q;
                        sp <= sp - SP_W'(1);
                     end
                     else
                        running <= 1'b0; // halt, pc already past it
                  OP_JP:   pc <= ins.nnn;
                  OP_CALL:
                  begin
                     pc <= ins.nnn;
                     sp <= sp + SP_W'(1);
                  end
                  OP_SE_BYTE:
                     if (vx == ins.kk)
                        pc <= pc + 12'd4;
                  OP_SNE_BYTE:
                     if (vx != ins.kk)
                        pc <= pc + 12'd4;
                  OP_SE_REG:
                     if (vx == vy)
                        pc <= pc + 12'd4;
                  OP_SNE_REG:
                     if (vx != vy)
                        pc <= pc + 12'd4;
                  OP_LD_BYTE:  v[ins.x] <= ins.kk;
                  OP_ADD_BYTE: v[ins.x] <= vx + ins.kk; // no carry flag
                  OP_ALU:
                     if (alu_wr)
                     begin
                        v[ins.x] <= alu_res;
                        if (flag_we)
                           v[4'hF] <= {7'h0, alu_flag}; // flag beats result on VF
                     end
                  OP_LD_I:  i_reg <= {4'h0, ins.nnn};
                  OP_JP_V0: pc <= ins.nnn + addr_t'(v[0]);
                  OP_MISC:
                     if (ins.kk == 8'h1E)
                        i_reg <= i_reg + 16'(vx);
                  default: ;
               endcase
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

endmodule

//--- verilog/chip8_core.sv
`include "chip8_macros.svh"

module chip8_core
   import chip8_isa_pkg::*;
   import chip8_apb_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  apb_req_t req,
   output apb_rsp_t rsp
);

   mem_wr_t                               prog_wr;
   logic                                  start;
   vidx_t                                 dbg_vidx;
   core_status_t                          status;
   byte_t                                 dbg_vdata;
   addr_t                                 mem_raddr;
   byte_t                                 mem_q;
   logic                                  stack_we;
   logic [$clog2(`CHIP8_STACK_DEPTH)-1:0] stack_waddr;
   logic [$clog2(`CHIP8_STACK_DEPTH)-1:0] stack_raddr;
   addr_t                                 stack_d;
   addr_t                                 stack_q;

   chip8_apb_host host (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .status    (status),
      .dbg_vdata (dbg_vdata),
      .rsp       (rsp),
      .prog_wr   (prog_wr),
      .start     (start),
      .dbg_vidx  (dbg_vidx)
   );

   chip8_exec exec (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .dbg_vidx    (dbg_vidx),
      .mem_q       (mem_q),
      .stack_q     (stack_q),
      .status      (status),
      .dbg_vdata   (dbg_vdata),
      .mem_raddr   (mem_raddr),
      .stack_we    (stack_we),
      .stack_waddr (stack_waddr),
      .stack_raddr (stack_raddr),
      .stack_d     (stack_d)
   );

   chip8_ram #(.payload_t(byte_t), .depth(`CHIP8_MEM_DEPTH)) prog_mem (
      .clk   (clk),
      .we    (prog_wr.we),
      .waddr (prog_wr.addr),
      .d     (prog_wr.data),
      .raddr (mem_raddr),
      .q     (mem_q)
   );

   chip8_ram #(.payload_t(addr_t), .depth(`CHIP8_STACK_DEPTH)) call_stack (
      .clk   (clk),
      .we    (stack_we),
      .waddr (stack_waddr),
      .d     (stack_d),
      .raddr (stack_raddr),
      .q     (stack_q)
   );

endmodule

//--- verification/chip8_clk_gen.sv
module chip8_clk_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- verification/chip8_sva.sv
`include "chip8_macros.svh"

module chip8_sva
   import chip8_isa_pkg::*;
   import chip8_apb_pkg::*;
(
   input logic         clk,
   input logic         rst_n,
   input apb_req_t     req,
   input apb_rsp_t     rsp,
   input core_status_t status
);

   logic access;
   logic ctrl_write;
   logic prog_write;
   int   fail_count = 0;

   assign access     = req.psel & req.penable;
   assign ctrl_write = access & req.pwrite & ~req.paddr[`CHIP8_ADDR_W]
                     & (req.paddr[`CHIP8_ADDR_W-1:0] == `CHIP8_REG_CTRL);
   assign prog_write = access & req.pwrite & req.paddr[`CHIP8_ADDR_W];

   pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
      access |-> rsp.pready)
   else
   begin
      $error("pready low in an APB access phase");
      fail_count++;
   end

   pslverr_only_in_access: assert property (@(posedge clk) disable iff (!rst_n)
      !access |-> !rsp.pslverr)
   else
   begin
      $error("pslverr high outside an APB access phase");
      fail_count++;
   end

   // core only starts from a CTRL write
   start_needs_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(status.running) |-> $past(ctrl_write))
   else
   begin
      $error("running rose without a CTRL write");
      fail_count++;
   end

   // running sampled in setup, when the host decides
   prog_write_while_running: assert property (@(posedge clk) disable iff (!rst_n)
      prog_write && $past(status.running) |-> rsp.pslverr)
   else
   begin
      $error("program write while running got no pslverr");
      fail_count++;
   end

endmodule

bind chip8_core chip8_sva sva_checks (
   .clk    (clk),
   .rst_n  (rst_n),
   .req    (req),
   .rsp    (rsp),
   .status (status)
);

//--- verification/chip8_tb.sv
`include "chip8_macros.svh"

module chip8_tb
   import chip8_isa_pkg::*;
   import chip8_apb_pkg::*;
();

   localparam logic [3:0] alu_ops [10] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4,
                                          4'h5, 4'h6, 4'h7, 4'hE, 4'h8};

   // {address, instruction}
   localparam logic [27:0] flow_prog [20] = '{
      28'h200_6100, 28'h202_6200, 28'h204_6300, 28'h206_6400,
      28'h208_6500, 28'h20A_6004, 28'h20C_1212, 28'h20E_61EE,
      28'h210_0000, 28'h212_2230, 28'h214_B216, 28'h216_62EE,
      28'h218_0000, 28'h21A_6333, 28'h21C_0000, 28'h230_2240,
      28'h232_6444, 28'h234_00EE, 28'h240_6555, 28'h242_00EE};

   logic        clk;
   logic        rst_n;
   apb_req_t    req;
   apb_rsp_t    rsp;
   logic [15:0] prog [$];
   byte_t       exp_v [16];
   logic [15:0] exp_i;
   addr_t       exp_pc;
   int          errors;
   int          seed;

   chip8_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

   chip8_core uut (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

   task automatic bus_access(input logic write, input logic [`CHIP8_PADDR_W-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(posedge clk);
      req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(posedge clk);
      req.penable <= 1'b1;
      @(negedge clk); // mid access phase
      rdata = rsp.prdata;
      err   = rsp.pslverr;
      @(posedge clk);
      req <= '0;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic write_checked(input logic [`CHIP8_PADDR_W-1:0] addr, input logic [31:0] data,
                                input logic exp_err, input string what);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b1, addr, data, rdata, err);
      check_value({"pslverr on ", what}, 32'(err), 32'(exp_err));
   endtask

   task automatic read_checked(input logic [`CHIP8_PADDR_W-1:0] addr, input logic [31:0] exp,
                               input string what);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b0, addr, 32'h0, rdata, err);
      check_value({"pslverr on ", what}, 32'(err), 32'h0);
      check_value(what, rdata, exp);
   endtask

   task automatic put_instr(input addr_t addr, input logic [15:0] word);
      write_checked({1'b1, addr}, {24'h0, word[15:8]}, 1'b0, "program byte");
      write_checked({1'b1, addr + 12'd1}, {24'h0, word[7:0]}, 1'b0, "program byte");
   endtask

   task automatic load_program();
      foreach (prog[k])
         put_instr(`CHIP8_PC_RESET + 12'(2 * k), prog[k]);
   endtask

   task automatic check_state();
      read_checked({1'b0, `CHIP8_REG_STATUS}, {4'h0, exp_pc, 16'h0}, "STATUS");
      read_checked({1'b0, `CHIP8_REG_I}, {16'h0, exp_i}, "I");
      for (int k = 0; k < 16; k++)
         read_checked({1'b0, `CHIP8_REG_V_BASE + 12'(4 * k)}, {24'h0, exp_v[k]},
                      $sformatf("V%0h", k));
   endtask

   task automatic start_core();
      write_checked({1'b0, `CHIP8_REG_CTRL}, 32'h1, 1'b0, "CTRL");
   endtask

   task automatic wait_for_halt(input addr_t halt_pc);
      logic [31:0] rdata;
      logic        err;
      int          polls;
      polls = 0;
      rdata = 32'h1;
      while (rdata[0] && polls < 2000)
      begin
         bus_access(1'b0, {1'b0, `CHIP8_REG_STATUS}, 32'h0, rdata, err);
         polls++;
      end
      if (rdata[0])
      begin
         errors++;
         $display("core never halted after %0d status polls", polls);
      end
      exp_pc = halt_pc + 12'd2; // pc moves past the halt
      check_state();
   endtask

   // reference ALU model for 8xyN
   task automatic model_alu(input vidx_t x, input vidx_t y, input logic [3:0] n);
      byte_t      vx;
      byte_t      vy;
      byte_t      res;
      logic [8:0] sum;
      logic       flag;
      logic       has_flag;
      logic       writes;
      vx       = exp_v[x];
      vy       = exp_v[y];
      res      = vx;
      flag     = 1'b0;
      has_flag = n inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
      writes   = 1'b1;
      case (n)
         4'h0: res = vy;
         4'h1: res = vx | vy;
         4'h2: res = vx & vy;
         4'h3: res = vx ^ vy;
         4'h4:
         begin
            sum  = {1'b0, vx} + {1'b0, vy};
            res  = sum[7:0];
            flag = sum[8];
         end
         4'h5:
         begin
            res  = vx - vy;
            flag = vx > vy;
         end
         4'h6:
         begin
            res  = vx >> 1;
            flag = vx[0];
         end
         4'h7:
         begin
            res  = vy - vx;
            flag = vy > vx;
         end
         4'hE:
         begin
            res  = vx << 1;
            flag = vx[7];
         end
         default: writes = 1'b0;
      endcase
      if (writes)
         exp_v[x] = res;
      if (writes && has_flag)
         exp_v[15] = {7'h0, flag}; // VF written last
   endtask

   task automatic alu_case(input logic [3:0] n, input vidx_t x, input byte_t a, input byte_t b);
      prog.delete();
      prog.push_back({4'h6, x, a});
      prog.push_back({8'h62, b});
      prog.push_back({4'h8, x, 4'h2, n});
      prog.push_back(16'h0000);
      exp_v[x] = a;
      exp_v[2] = b;
      model_alu(x, 4'h2, n);
      load_program();
      start_core();
      wait_for_halt(`CHIP8_PC_RESET + 12'h6);
   endtask

   task automatic skip_case(input logic [15:0] skip_instr, input byte_t p, input byte_t q,
                            input byte_t mark);
      logic taken;
      case (skip_instr[15:12])
         4'h3: taken = p == skip_instr[7:0];
         4'h4: taken = p != skip_instr[7:0];
         4'h5: taken = p == q;
         default: taken = p != q;
      endcase
      prog.delete();
      prog.push_back(16'h6500);
      prog.push_back({8'h61, p});
      prog.push_back({8'h62, q});
      prog.push_back(skip_instr);
      prog.push_back({8'h65, mark});
      prog.push_back(16'h0000);
      exp_v[1] = p;
      exp_v[2] = q;
      exp_v[5] = taken ? 8'h00 : mark;
      load_program();
      start_core();
      wait_for_halt(`CHIP8_PC_RESET + 12'hA);
   endtask

   initial
   begin
      int          cycles;
      byte_t       a;
      byte_t       b;
      addr_t       nnn;
      logic [31:0] rdata;
      logic        err;
      req    <= '0;
      errors = 0;
      seed   = 37517;
      exp_i  = 16'h0;
      exp_pc = `CHIP8_PC_RESET;
      foreach (exp_v[k])
         exp_v[k] = 8'h00;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < 20)
      begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1)
      begin
         errors++;
         $display("reset was never released");
      end

      check_state();

      // loads and ALU
      foreach (alu_ops[k])
         for (int r = 0; r < 3; r++)
         begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            alu_case(alu_ops[k], 4'h3, a, b);
         end
      alu_case(4'h4, 4'h3, 8'hF0, 8'h20);
      alu_case(4'h5, 4'h3, 8'h42, 8'h42); // equal, no flag
      alu_case(4'h7, 4'h3, 8'h10, 8'h30);
      alu_case(4'h6, 4'h3, 8'h81, 8'h00);
      alu_case(4'hE, 4'h3, 8'h81, 8'h00);
      alu_case(4'h4, 4'hF, 8'h10, 8'h20);
      alu_case(4'h5, 4'hF, 8'h50, 8'h10);
      a = 8'($random(seed));
      b = 8'($random(seed));
      prog.delete();
      prog.push_back({8'h63, a});
      prog.push_back({8'h73, b});
      prog.push_back(16'h0000);
      exp_v[3] = a + b;
      load_program();
      start_core();
      wait_for_halt(`CHIP8_PC_RESET + 12'h4);

      // skips, taken and not taken
      a = 8'($random(seed));
      skip_case({8'h31, a}, a, 8'h00, 8'hA1);
      skip_case({8'h31, a ^ 8'h01}, a, 8'h00, 8'hA2);
      skip_case({8'h41, a}, a, 8'h00, 8'hA3);
      skip_case({8'h41, a ^ 8'h01}, a, 8'h00, 8'hA4);
      skip_case(16'h5120, a, a, 8'hA5);
      skip_case(16'h5120, a, a ^ 8'h55, 8'hA6);
      skip_case(16'h9120, a, a, 8'hA7);
      skip_case(16'h9120, a, a ^ 8'h55, 8'hA8);

      // jump, nested call and return, Bnnn
      foreach (flow_prog[k])
         put_instr(flow_prog[k][27:16], flow_prog[k][15:0]);
      exp_v[0] = 8'h04;
      exp_v[1] = 8'h00;
      exp_v[2] = 8'h00;
      exp_v[3] = 8'h33;
      exp_v[4] = 8'h44;
      exp_v[5] = 8'h55;
      start_core();
      wait_for_halt(12'h21C);

      // index register
      nnn = 12'($random(seed));
      a   = 8'($random(seed));
      prog.delete();
      prog.push_back({8'h67, a});
      prog.push_back({4'hA, nnn});
      prog.push_back(16'hF71E);
      prog.push_back(16'h0000);
      exp_v[7] = a;
      exp_i    = 16'(nnn) + 16'(a);
      load_program();
      start_core();
      wait_for_halt(`CHIP8_PC_RESET + 12'h6);

      // bus errors during a counting loop
      prog.delete();
      prog.push_back(16'h6A00);
      prog.push_back(16'h7A01);
      prog.push_back(16'h3A40);
      prog.push_back(16'h1202);
      prog.push_back(16'h0000);
      exp_v[10] = 8'h40;
      load_program();
      start_core();
      write_checked({1'b1, 12'h300}, 32'h5A, 1'b1, "program write while running");
      write_checked({1'b0, `CHIP8_REG_STATUS}, 32'h1, 1'b1, "STATUS write");
      bus_access(1'b0, {1'b0, 12'h010}, 32'h0, rdata, err);
      check_value("pslverr on unmapped read", 32'(err), 32'h1);
      wait_for_halt(`CHIP8_PC_RESET + 12'h8);

      $display("Closing report: %0d testbench errors, %0d assertion failures",
               errors, uut.sva_checks.fail_count);
      if (errors == 0 && uut.sva_checks.fail_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- chip8_core.f
+incdir+verilog
verilog/chip8_isa_pkg.sv
verilog/chip8_apb_pkg.sv
verilog/chip8_ram.sv
verilog/chip8_apb_host.sv
verilog/chip8_exec.sv
verilog/chip8_core.sv
verification/chip8_clk_gen.sv
verification/chip8_sva.sv
verification/chip8_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = chip8_tb
FILELIST  = chip8_core.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
